//--- common/soc_pkg.sv
package soc_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int FIFO_DEPTH = 4;
  localparam int MEM_WORDS  = 256;
  localparam int GPIO_W     = 8;

  // word offset inside a slave region, sized for the memory
  localparam int OFFS_W = $clog2(MEM_WORDS);

  localparam logic [ADDR_W-1:0] MEM_BASE   = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] MEM_BYTES  = ADDR_W'(MEM_WORDS * 4);
  localparam logic [ADDR_W-1:0] GPIO_BASE  = 32'h1000_0000;
  // two word registers, output data then input data
  localparam logic [ADDR_W-1:0] GPIO_BYTES = 32'h0000_0008;

  localparam logic [OFFS_W-1:0] GPIO_OUT_OFFS = '0;

  localparam logic [DATA_W-1:0] ERR_RDATA = 32'hDEAD_BEEF;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [DATA_W-1:0] wdata;
  } req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } rsp_t;

  typedef enum logic [1:0] {
    SEL_MEM,
    SEL_GPIO,
    SEL_ERR
  } sel_e;

endpackage

//--- common/slave_if.sv
`timescale 1ns/1ps

interface slave_if import soc_pkg::*; ();

  // request, held for the single cycle sel is high
  logic              sel;
  logic [OFFS_W-1:0] addr;
  logic              write;
  logic [DATA_W-1:0] wdata;

  // response, one cycle after sel
  logic              rsp_valid;
  logic [DATA_W-1:0] rdata;

  modport controller (
    output sel,
    output addr,
    output write,
    output wdata,
    input  rsp_valid,
    input  rdata
  );

  modport slave (
    input  sel,
    input  addr,
    input  write,
    input  wdata,
    output rsp_valid,
    output rdata
  );

endinterface

//--- design/bus_fifo.sv
`timescale 1ns/1ps

module bus_fifo import soc_pkg::*; #(
  parameter type T     = logic [DATA_W-1:0],
  parameter int  DEPTH = FIFO_DEPTH
) (
  input  logic i_per_clk,
  input  logic i_reset,
  input  logic i_push,
  input  T     i_data,
  input  logic i_pop,
  output logic o_not_full,
  output logic o_not_empty,
  output T     o_data
);

  T                             mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]   count;
  logic                         do_push;
  logic                         do_pop;

  assign o_not_full  = (int'(count) != DEPTH);
  assign o_not_empty = (count != '0);

  // push on full and pop on empty are dropped
  assign do_push = i_push && o_not_full;
  assign do_pop  = i_pop && o_not_empty;

  assign o_data = mem[rd_ptr];

  always_ff @(posedge i_per_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge i_per_clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- design/bus_ctrl.sv
`timescale 1ns/1ps

module bus_ctrl import soc_pkg::*; (
  input  logic        i_per_clk,
  input  logic        i_reset,
  input  logic        i_req_not_empty,
  input  req_t        i_req,
  input  logic        i_rsp_not_full,
  output logic        o_req_pop,
  output logic        o_rsp_push,
  output rsp_t        o_rsp,
  slave_if.controller mem,
  slave_if.controller gpio
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MEM,
    ST_GPIO
  } state_e;

  state_e            state;
  sel_e              sel;
  logic [ADDR_W-1:0] mem_rel;
  logic [ADDR_W-1:0] gpio_rel;
  logic              issue;

  // offsets relative to each region base
  assign mem_rel  = i_req.addr - MEM_BASE;
  assign gpio_rel = i_req.addr - GPIO_BASE;

  always_comb begin
    if (i_req.addr[1:0] != 2'b00) begin
      sel = SEL_ERR;
    end else if (mem_rel < MEM_BYTES) begin
      sel = SEL_MEM;
    end else if (gpio_rel < GPIO_BYTES) begin
      sel = SEL_GPIO;
    end else begin
      sel = SEL_ERR;
    end
  end

  // pop only with room for the response
  assign issue     = (state == ST_IDLE) && i_req_not_empty && i_rsp_not_full;
  assign o_req_pop = issue;

  assign mem.sel   = issue && (sel == SEL_MEM);
  assign mem.addr  = mem_rel[OFFS_W+1:2];
  assign mem.write = i_req.write;
  assign mem.wdata = i_req.wdata;

  assign gpio.sel   = issue && (sel == SEL_GPIO);
  assign gpio.addr  = gpio_rel[OFFS_W+1:2];
  assign gpio.write = i_req.write;
  assign gpio.wdata = i_req.wdata;

  // which slave owes a response
  always_ff @(posedge i_per_clk) begin
    if (i_reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (mem.sel) begin
            state <= ST_MEM;
          end else if (gpio.sel) begin
            state <= ST_GPIO;
          end
        end
        ST_MEM: begin
          if (mem.rsp_valid) begin
            state <= ST_IDLE;
          end
        end
        ST_GPIO: begin
          if (gpio.rsp_valid) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_comb begin
    o_rsp_push  = 1'b0;
    o_rsp.rdata = ERR_RDATA;
    o_rsp.err   = 1'b1;
    case (state)
      ST_MEM: begin
        o_rsp_push  = mem.rsp_valid;
        o_rsp.rdata = mem.rdata;
        o_rsp.err   = 1'b0;
      end
      ST_GPIO: begin
        o_rsp_push  = gpio.rsp_valid;
        o_rsp.rdata = gpio.rdata;
        o_rsp.err   = 1'b0;
      end
      // unmapped or misaligned, answered in the pop cycle
      default: o_rsp_push = issue && (sel == SEL_ERR);
    endcase
  end

endmodule

//--- design/mem_slave.sv
`timescale 1ns/1ps

module mem_slave import soc_pkg::*; (
  input  logic   i_per_clk,
  slave_if.slave bus
);

  logic [DATA_W-1:0] mem [MEM_WORDS];

  always_ff @(posedge i_per_clk) begin
    if (bus.sel && bus.write) begin
      mem[bus.addr] <= bus.wdata;
    end
  end

  // response one cycle after sel
  always_ff @(posedge i_per_clk) begin
    bus.rsp_valid <= bus.sel;
    if (bus.sel) begin
      if (bus.write) begin
        bus.rdata <= '0;
      end else begin
        bus.rdata <= mem[bus.addr];
      end
    end
  end

endmodule

//--- design/gpio_slave.sv
`timescale 1ns/1ps

module gpio_slave import soc_pkg::*; (
  input  logic              i_per_clk,
  input  logic              i_reset,
  input  logic [GPIO_W-1:0] i_gpio_in,
  output logic [GPIO_W-1:0] o_gpio_out,
  slave_if.slave            bus
);

  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] in_meta;
  logic [GPIO_W-1:0] in_sync;

  assign o_gpio_out = out_q;

  // two-stage sync on the pins
  always_ff @(posedge i_per_clk) begin
    in_meta <= i_gpio_in;
    in_sync <= in_meta;
  end

  always_ff @(posedge i_per_clk) begin
    if (i_reset) begin
      out_q <= '0;
    end else if (bus.sel && bus.write && bus.addr == GPIO_OUT_OFFS) begin
      out_q <= bus.wdata[GPIO_W-1:0];
    end
  end

  always_ff @(posedge i_per_clk) begin
    if (i_reset) begin
      bus.rsp_valid <= 1'b0;
    end else begin
      bus.rsp_valid <= bus.sel;
    end
  end

  // writes return zero, input register is read only
  always_ff @(posedge i_per_clk) begin
    if (bus.sel) begin
      if (bus.write) begin
        bus.rdata <= '0;
      end else if (bus.addr == GPIO_OUT_OFFS) begin
        bus.rdata <= DATA_W'(out_q);
      end else begin
        bus.rdata <= DATA_W'(in_sync);
      end
    end
  end

endmodule

//--- design/soc.sv
`timescale 1ns/1ps

module soc import soc_pkg::*; (
  input  logic              i_pad_clk,
  input  logic              i_reset,
  input  logic              i_req_valid,
  input  logic [ADDR_W-1:0] i_req_addr,
  input  logic              i_req_write,
  input  logic [DATA_W-1:0] i_req_wdata,
  input  logic              i_rsp_ready,
  input  logic [GPIO_W-1:0] i_gpio_in,
  output logic              o_req_ready,
  output logic              o_rsp_valid,
  output logic [DATA_W-1:0] o_rsp_rdata,
  output logic              o_rsp_err,
  output logic [GPIO_W-1:0] o_gpio_out
);

  req_t req_in;
  req_t req_head;
  rsp_t rsp_tail;
  rsp_t rsp_out;
  logic req_not_empty;
  logic req_pop;
  logic rsp_push;
  logic rsp_not_full;

  slave_if mem_bus ();
  slave_if gpio_bus ();

  assign req_in = '{addr: i_req_addr, write: i_req_write, wdata: i_req_wdata};

  assign o_rsp_rdata = rsp_out.rdata;
  assign o_rsp_err   = rsp_out.err;

  bus_fifo #(
    .T     (req_t),
    .DEPTH (FIFO_DEPTH)
  ) u_req_fifo (
    .i_per_clk   (i_pad_clk),
    .i_reset     (i_reset),
    .i_push      (i_req_valid),
    .i_data      (req_in),
    .i_pop       (req_pop),
    .o_not_full  (o_req_ready),
    .o_not_empty (req_not_empty),
    .o_data      (req_head)
  );

  bus_ctrl u_bus_ctrl (
    .i_per_clk       (i_pad_clk),
    .i_reset         (i_reset),
    .i_req_not_empty (req_not_empty),
    .i_req           (req_head),
    .i_rsp_not_full  (rsp_not_full),
    .o_req_pop       (req_pop),
    .o_rsp_push      (rsp_push),
    .o_rsp           (rsp_tail),
    .mem             (mem_bus.controller),
    .gpio            (gpio_bus.controller)
  );

  // head stays put until the master takes it
  bus_fifo #(
    .T     (rsp_t),
    .DEPTH (FIFO_DEPTH)
  ) u_rsp_fifo (
    .i_per_clk   (i_pad_clk),
    .i_reset     (i_reset),
    .i_push      (rsp_push),
    .i_data      (rsp_tail),
    .i_pop       (i_rsp_ready),
    .o_not_full  (rsp_not_full),
    .o_not_empty (o_rsp_valid),
    .o_data      (rsp_out)
  );

  mem_slave u_mem_slave (
    .i_per_clk (i_pad_clk),
    .bus       (mem_bus.slave)
  );

  gpio_slave u_gpio_slave (
    .i_per_clk  (i_pad_clk),
    .i_reset    (i_reset),
    .i_gpio_in  (i_gpio_in),
    .o_gpio_out (o_gpio_out),
    .bus        (gpio_bus.slave)
  );

endmodule

//--- tb/soc_checker.sv
`timescale 1ns/1ps

module soc_checker import soc_pkg::*; (
  input logic              i_pad_clk,
  input logic              i_reset,
  input logic              i_req_ready,
  input logic              i_rsp_valid,
  input logic              i_rsp_ready,
  input logic [DATA_W-1:0] i_rsp_rdata,
  input logic              i_rsp_err
);

  int fail_count = 0;

  // response queue leaves reset empty
  rsp_idle_after_reset: assert property (@(posedge i_pad_clk) i_reset |=> !i_rsp_valid)
    else begin
      fail_count++;
      $error("o_rsp_valid high in the cycle after reset");
    end

  rsp_held_while_stalled: assert property (@(posedge i_pad_clk) disable iff (i_reset)
    (i_rsp_valid && !i_rsp_ready) |=>
      (i_rsp_valid && $stable(i_rsp_rdata) && $stable(i_rsp_err)))
    else begin
      fail_count++;
      $error("response changed before it was taken");
    end

  req_ready_in_reset: assert property (@(posedge i_pad_clk) i_reset |=> i_req_ready)
    else begin
      fail_count++;
      $error("o_req_ready low during reset");
    end

endmodule

bind soc soc_checker u_soc_checker (
  .i_pad_clk   (i_pad_clk),
  .i_reset     (i_reset),
  .i_req_ready (o_req_ready),
  .i_rsp_valid (o_rsp_valid),
  .i_rsp_ready (i_rsp_ready),
  .i_rsp_rdata (o_rsp_rdata),
  .i_rsp_err   (o_rsp_err)
);

//--- tb/tb_soc.sv
`timescale 1ns/1ps

module tb_soc import soc_pkg::*; ();

  localparam int          N_TRANS    = 300;
  localparam int          MAX_CYCLES = 40 * N_TRANS + 2000;
  localparam logic [31:0] LFSR_SEED  = 32'h9c01_4829;

  typedef struct packed {
    rsp_t              rsp;
    logic [GPIO_W-1:0] gpio;
    logic [31:0]       seq;
  } exp_t;

  logic              i_pad_clk;
  logic              i_reset;
  logic              i_req_valid;
  logic [ADDR_W-1:0] i_req_addr;
  logic              i_req_write;
  logic [DATA_W-1:0] i_req_wdata;
  logic              i_rsp_ready;
  logic [GPIO_W-1:0] i_gpio_in;
  logic              o_req_ready;
  logic              o_rsp_valid;
  logic [DATA_W-1:0] o_rsp_rdata;
  logic              o_rsp_err;
  logic [GPIO_W-1:0] o_gpio_out;

  exp_t              exp_q [$];
  logic [DATA_W-1:0] mem_model [MEM_WORDS];
  logic              written [MEM_WORDS];
  logic [GPIO_W-1:0] gpio_model;
  logic [31:0]       gpio_cnt;
  logic [31:0]       gpio_cnt_q;
  logic [31:0]       prod_lfsr;
  logic [31:0]       cons_lfsr;
  logic              req_ready_fell;
  int                value_errs;
  int                other_errs;
  int                cycles;

  soc soc_inst (.*);

  initial begin
    i_pad_clk = 1'b0;
    forever #10 i_pad_clk = ~i_pad_clk;
  end

  // count of GPIO output writes as seen at the last rising edge
  always @(posedge i_pad_clk) begin
    gpio_cnt_q <= gpio_cnt;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      st  = lfsr_step(st);
      val = {val[30:0], st[0]};
    end
  endtask

  function automatic rsp_t make_rsp(input logic [DATA_W-1:0] rdata, input logic err);
    rsp_t r;
    r.rdata = rdata;
    r.err   = err;
    return r;
  endfunction

  task automatic check_rsp(input rsp_t got, input rsp_t exp);
    if (got.rdata !== exp.rdata) begin
      value_errs++;
      $display("error o_rsp_rdata got 0x%08h expected 0x%08h", got.rdata, exp.rdata);
    end
    if (got.err !== exp.err) begin
      value_errs++;
      $display("error o_rsp_err got 0x%0h expected 0x%0h", got.err, exp.err);
    end
  endtask

  task automatic check_gpio(input logic [GPIO_W-1:0] got, input logic [GPIO_W-1:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("error o_gpio_out got 0x%02h expected 0x%02h", got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_counts();
    $display("errors: %0d value, %0d other, %0d assertion", value_errs, other_errs,
             soc_inst.u_soc_checker.fail_count);
  endtask

  task automatic send_req(input logic [ADDR_W-1:0] addr, input logic write,
                          input logic [DATA_W-1:0] wdata, input rsp_t rsp);
    exp_t e;
    i_req_valid = 1'b1;
    i_req_addr  = addr;
    i_req_write = write;
    i_req_wdata = wdata;
    while (!o_req_ready) @(negedge i_pad_clk);
    // transfer happens on the coming rising edge
    e.rsp  = rsp;
    e.gpio = gpio_model;
    e.seq  = gpio_cnt;
    exp_q.push_back(e);
    @(negedge i_pad_clk);
    i_req_valid = 1'b0;
  endtask

  task automatic pick_bad_addr(output logic [ADDR_W-1:0] addr);
    logic [31:0] mode;
    logic [31:0] r;
    take_bits(prod_lfsr, 2, mode);
    take_bits(prod_lfsr, 8, r);
    case (mode[1:0])
      2'd0:    addr = MEM_BASE + ADDR_W'({r[7:2], 2'b01});
      2'd1:    addr = GPIO_BASE + ADDR_W'({r[0], 2'b10});
      2'd2:    addr = MEM_BYTES + ADDR_W'({r[7:0], 2'b00});
      default: addr = GPIO_BASE + GPIO_BYTES + ADDR_W'({r[7:0], 2'b00});
    endcase
  endtask

  task automatic run_producer();
    logic [31:0]       kind;
    logic [31:0]       r;
    logic [31:0]       wdata;
    logic [7:0]        idx;
    logic [ADDR_W-1:0] addr;
    int                n;
    for (n = 0; n < N_TRANS; n++) begin
      take_bits(prod_lfsr, 4, kind);
      take_bits(prod_lfsr, 32, wdata);
      take_bits(prod_lfsr, 4, r);
      // few words, so reads hit earlier writes
      idx  = {4'h0, r[3:0]};
      addr = MEM_BASE + ADDR_W'({idx, 2'b00});
      if (kind < 32'd6 || (kind < 32'd11 && !written[idx])) begin
        mem_model[idx] = wdata;
        written[idx]   = 1'b1;
        send_req(addr, 1'b1, wdata, make_rsp('0, 1'b0));
      end else if (kind < 32'd11) begin
        send_req(addr, 1'b0, wdata, make_rsp(mem_model[idx], 1'b0));
      end else if (kind == 32'd11) begin
        gpio_model = wdata[GPIO_W-1:0];
        gpio_cnt   = gpio_cnt + 32'd1;
        send_req(GPIO_BASE, 1'b1, wdata, make_rsp('0, 1'b0));
      end else if (kind == 32'd12) begin
        send_req(GPIO_BASE, 1'b0, wdata, make_rsp(DATA_W'(gpio_model), 1'b0));
      end else if (kind == 32'd13) begin
        send_req(GPIO_BASE + 32'd4, 1'b1, wdata, make_rsp('0, 1'b0));
      end else if (kind == 32'd14) begin
        pick_bad_addr(addr);
        send_req(addr, wdata[0], wdata, make_rsp(ERR_RDATA, 1'b1));
      end else begin
        // input pins change only with the bus drained
        while (exp_q.size() != 0) @(negedge i_pad_clk);
        i_gpio_in = wdata[GPIO_W-1:0];
        repeat (4) @(negedge i_pad_clk);
        send_req(GPIO_BASE + 32'd4, 1'b0, '0, make_rsp(DATA_W'(i_gpio_in), 1'b0));
      end
      take_bits(prod_lfsr, 2, r);
      if (r == 32'd0) begin
        @(negedge i_pad_clk);
      end
    end
  endtask

  task automatic run_consumer();
    logic [31:0] r;
    int          stall;
    int          received;
    exp_t        e;
    stall    = 0;
    received = 0;
    while (received < N_TRANS) begin
      @(negedge i_pad_clk);
      if (stall > 0) begin
        stall--;
        i_rsp_ready = 1'b0;
      end else begin
        take_bits(cons_lfsr, 5, r);
        if (r == 32'd0) begin
          take_bits(cons_lfsr, 5, r);
          stall       = 8 + int'(r);
          i_rsp_ready = 1'b0;
        end else begin
          i_rsp_ready = 1'b1;
        end
      end
      if (!o_req_ready) begin
        req_ready_fell = 1'b1;
      end
      if (o_rsp_valid && i_rsp_ready) begin
        if (exp_q.size() == 0) begin
          other_errs++;
          $display("a response arrived with no request outstanding");
        end else begin
          e = exp_q.pop_front();
          check_rsp(rsp_t'({o_rsp_rdata, o_rsp_err}), e.rsp);
          // skip when a later GPIO write may already have landed
          if (gpio_cnt_q == e.seq) begin
            check_gpio(o_gpio_out, e.gpio);
          end
        end
        received++;
      end
    end
  endtask

  initial begin
    int i;
    i_reset        = 1'b1;
    i_req_valid    = 1'b0;
    i_req_addr     = '0;
    i_req_write    = 1'b0;
    i_req_wdata    = '0;
    i_rsp_ready    = 1'b0;
    i_gpio_in      = '0;
    value_errs     = 0;
    other_errs     = 0;
    gpio_model     = '0;
    gpio_cnt       = '0;
    req_ready_fell = 1'b0;
    prod_lfsr      = LFSR_SEED;
    cons_lfsr      = LFSR_SEED;
    for (i = 0; i < MEM_WORDS; i++) begin
      written[i] = 1'b0;
    end
    repeat (16) @(posedge i_pad_clk);
    @(negedge i_pad_clk);
    i_reset = 1'b0;
    check_flag("o_rsp_valid", o_rsp_valid, 1'b0);
    check_flag("o_req_ready", o_req_ready, 1'b1);
    check_gpio(o_gpio_out, '0);
    fork
      run_producer();
      run_consumer();
    join
    // last response leaves on the next rising edge, then hold the rest
    @(negedge i_pad_clk);
    i_rsp_ready = 1'b0;
    repeat (8) @(negedge i_pad_clk);
    // anything still valid here is a duplicate
    check_flag("o_rsp_valid", o_rsp_valid, 1'b0);
    check_gpio(o_gpio_out, gpio_model);
    if (!req_ready_fell) begin
      other_errs++;
      $display("o_req_ready never dropped while responses were held back");
    end
    report_counts();
    if (value_errs == 0 && other_errs == 0 && soc_inst.u_soc_checker.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge i_pad_clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the bus stopped answering requests", cycles);
    report_counts();
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- tb.f
common/soc_pkg.sv
common/slave_if.sv
design/bus_fifo.sv
design/bus_ctrl.sv
design/mem_slave.sv
design/gpio_slave.sv
design/soc.sv
tb/soc_checker.sv
tb/tb_soc.sv

//--- run.sh
#!/bin/sh
# build with Verilator, then run and look for the pass line
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module tb_soc -f tb.f \
  && ./obj_dir/Vtb_soc +verilator+error+limit+100 2>&1 | tee /dev/stderr \
  | grep -q "Simulation completed successfully" \
  && echo "PASS" || { echo "FAIL"; exit 1; }
